//--- logic/bf_pkg.sv
/*
 * shared definitions for the four-channel complex beamformer
 * channel count and the widths of samples, weights and products
 * fixed point constant for the signed Q1.7 weights
 * complex sample and weight structs, and the weight write command
 */
package bf_pkg;

    // number of antenna channels summed into one beam
    localparam int NUM_CHANNELS = 4;

    // width of one real or imaginary sample part
    localparam int SAMPLE_WIDTH = 16;

    // width of one real or imaginary weight part
    localparam int WEIGHT_WIDTH = 8;

    // weights are Q1.7, so all bits but the sign bit are fraction bits
    localparam int WEIGHT_FRAC = WEIGHT_WIDTH - 1;

    // a signed sample times a signed weight fits in the sum of the two widths
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH;

    // enough bits to address any of the channels in the weight registers
    localparam int CHANNEL_INDEX_WIDTH = $clog2(NUM_CHANNELS);

    // one signed sample part
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one signed Q1.7 weight part, 64 is one half and -128 is minus one
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // complex sample, real part in the upper half of the packed word
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // complex channel weight
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // write command for the weight registers, the channel picks the target
    typedef struct packed {
        logic [CHANNEL_INDEX_WIDTH-1:0] channel;
        cplx_weight_t                   weight;
    } weight_write_t;

endpackage

//--- logic/weight_regs.sv
/*
 * register block holding one complex weight per channel
 * written one channel at a time, read back combinationally
 */
module weight_regs
    import bf_pkg::*;
(
    input  logic          clock,
    input  logic          resetn,

    // write port, the weight lands on the edge where weight_we is high
    input  logic          weight_we,
    input  weight_write_t weight_wr,

    // current weights, one per channel, straight from the registers
    output cplx_weight_t  weights [NUM_CHANNELS]
);

    // one-hot write select, one bit per channel
    logic [NUM_CHANNELS-1:0] channel_sel;

    // decode the channel field of the write command
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            channel_sel[c] = weight_we && (weight_wr.channel == CHANNEL_INDEX_WIDTH'(c));
        end
    end

    // the weight registers themselves
    always_ff @(posedge clock) begin
        if (!resetn) begin
            // a zero weight mutes its channel until software sets it
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                weights[c] <= '0;
            end
        end else begin
            // only the addressed channel changes, the rest keep their value
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (channel_sel[c]) begin
                    weights[c] <= weight_wr.weight;
                end
            end
        end
    end

    // weights are expected to change only while no beat is in flight,
    // otherwise a beat could see the old weight in one channel and the
    // new weight in another, since the weighters read them unregistered

endmodule

//--- logic/channel_weighter.sv
/*
 * complex multiply of one channel's samples by the channel weight
 * stage one holds the four full precision partial products per sample
 * stage two holds the shifted and truncated complex result
 */
module channel_weighter
    import bf_pkg::*;
#(
    parameter int SAMPLES = 8
) (
    input  logic         clock,

    // pipeline enable from the combiner, both stages move together
    input  logic         advance,

    // this channel's row of the input beat
    input  cplx_sample_t samples [SAMPLES],

    // this channel's weight from the register block
    input  cplx_weight_t weight,

    // weighted samples, two advances after the beat was taken
    output cplx_sample_t weighted [SAMPLES]
);

    // one full precision signed product
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    // the four partial products of one complex multiply
    // rr is sample re times weight re, ii is sample im times weight im,
    // ri is sample re times weight im, ir is sample im times weight re
    typedef struct packed {
        product_t rr;
        product_t ii;
        product_t ri;
        product_t ir;
    } product_set_t;

    product_set_t products_next [SAMPLES];
    product_set_t products_q    [SAMPLES];

    // full precision real and imaginary parts before the shift
    product_t re_full [SAMPLES];
    product_t im_full [SAMPLES];

    cplx_sample_t weighted_next [SAMPLES];

    // both operands are sign extended to the product width first, so the
    // multiply is signed and nothing is lost
    always_comb begin
        for (int i = 0; i < SAMPLES; i++) begin
            products_next[i].rr = product_t'(samples[i].re) * product_t'(weight.re);
            products_next[i].ii = product_t'(samples[i].im) * product_t'(weight.im);
            products_next[i].ri = product_t'(samples[i].re) * product_t'(weight.im);
            products_next[i].ir = product_t'(samples[i].im) * product_t'(weight.re);
        end
    end

    // stage one
    always_ff @(posedge clock) begin
        if (advance) begin
            products_q <= products_next;
        end
    end

    // combine the partial products into the complex result
    // the worst case magnitude is just under 2**23, so the difference and
    // the sum still fit in the product width
    always_comb begin
        for (int i = 0; i < SAMPLES; i++) begin
            re_full[i] = products_q[i].rr - products_q[i].ii;
            im_full[i] = products_q[i].ri + products_q[i].ir;

            // drop the Q1.7 fraction bits, then keep the low sample bits
            // which wraps rather than saturates on overflow
            weighted_next[i].re = sample_t'(re_full[i] >>> WEIGHT_FRAC);
            weighted_next[i].im = sample_t'(im_full[i] >>> WEIGHT_FRAC);
        end
    end

    // stage two
    always_ff @(posedge clock) begin
        if (advance) begin
            weighted <= weighted_next;
        end
    end

endmodule

//--- logic/beam_combiner.sv
/*
 * cross-channel sum of the weighted samples into the output register
 * pipeline enable that stalls every stage under back-pressure
 * valid and last chain matching the three stage data path
 */
module beam_combiner
    import bf_pkg::*;
#(
    parameter int SAMPLES = 8
) (
    input  logic         clock,
    input  logic         resetn,

    // control of the beat being taken into stage one
    input  logic         s_valid,
    input  logic         s_last,

    // stage two results of all weighters
    input  cplx_sample_t weighted [NUM_CHANNELS][SAMPLES],

    input  logic         m_ready,

    // high whenever the output register can take a new value
    output logic         advance,

    // output stream, this is stage three
    output logic         m_valid,
    output logic         m_last,
    output cplx_sample_t m_data [SAMPLES]
);

    // control bits that follow a beat down the pipeline
    typedef struct packed {
        logic valid;
        logic last;
    } beat_ctrl_t;

    // entry 0 matches the weighter stage one, entry 1 matches stage two
    beat_ctrl_t ctrl_q [2];

    cplx_sample_t sum_next [SAMPLES];

    // the whole pipeline moves when the output is empty or being taken,
    // so a stall at the output holds every stage in place
    assign advance = !m_valid || m_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            ctrl_q[0] <= '0;
            ctrl_q[1] <= '0;
            m_valid   <= 1'b0;
            m_last    <= 1'b0;
        end else if (advance) begin
            // a bubble never carries a last flag
            ctrl_q[0].valid <= s_valid;
            ctrl_q[0].last  <= s_valid && s_last;
            ctrl_q[1]       <= ctrl_q[0];
            m_valid         <= ctrl_q[1].valid;
            m_last          <= ctrl_q[1].last;
        end
    end

    // add the channels sample by sample
    // the accumulator has the sample width, so the sum wraps on overflow
    always_comb begin
        for (int s = 0; s < SAMPLES; s++) begin
            sum_next[s] = '0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                sum_next[s].re = sum_next[s].re + weighted[c][s].re;
                sum_next[s].im = sum_next[s].im + weighted[c][s].im;
            end
        end
    end

    // output register, loads together with the control chain
    // bubbles load too, their data is ignored since m_valid is low
    always_ff @(posedge clock) begin
        if (advance) begin
            m_data <= sum_next;
        end
    end

endmodule

//--- logic/beamformer_top.sv
/*
 * top level of the four-channel complex beamformer
 * weight register block, one weighter per channel and the combiner
 * input ready derived from the pipeline enable and reset
 */
module beamformer_top
    import bf_pkg::*;
#(
    parameter int SAMPLES = 8
) (
    input  logic          clock,
    input  logic          resetn,

    // input stream, one row of complex samples per channel
    input  logic          s_valid,
    output logic          s_ready,
    input  logic          s_last,
    input  cplx_sample_t  s_data [NUM_CHANNELS][SAMPLES],

    // output stream, the combined beam
    input  logic          m_ready,
    output logic          m_valid,
    output logic          m_last,
    output cplx_sample_t  m_data [SAMPLES],

    // weight write port
    input  logic          weight_we,
    input  weight_write_t weight_wr
);

    // pipeline enable from the combiner to every weighter
    logic advance;

    // current channel weights
    cplx_weight_t weights [NUM_CHANNELS];

    // stage two results, one row per channel
    cplx_sample_t weighted [NUM_CHANNELS][SAMPLES];

    // a beat is taken whenever the pipeline moves, but never during reset
    assign s_ready = advance && resetn;

    weight_regs weight_regs_i (
        .clock     (clock),
        .resetn    (resetn),
        .weight_we (weight_we),
        .weight_wr (weight_wr),
        .weights   (weights)
    );

    // one weighter per antenna channel
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : gen_channel
        channel_weighter #(
            .SAMPLES (SAMPLES)
        ) channel_weighter_i (
            .clock    (clock),
            .advance  (advance),
            .samples  (s_data[c]),
            .weight   (weights[c]),
            .weighted (weighted[c])
        );
    end

    // the combiner also owns the valid and last chain
    beam_combiner #(
        .SAMPLES (SAMPLES)
    ) beam_combiner_i (
        .clock    (clock),
        .resetn   (resetn),
        .s_valid  (s_valid),
        .s_last   (s_last),
        .weighted (weighted),
        .m_ready  (m_ready),
        .advance  (advance),
        .m_valid  (m_valid),
        .m_last   (m_last),
        .m_data   (m_data)
    );

endmodule

//--- include/bf_tb_model.svh
/*
 * reference model of one beamformer beat
 * compare tasks for output vectors and last flags
 * needs bf_pkg and a SAMPLES constant visible where it is included
 */
`ifndef BF_TB_MODEL_SVH
`define BF_TB_MODEL_SVH

// expected output vector for one beat under the given weights
function automatic void beam_model(
    input  cplx_sample_t data [NUM_CHANNELS][SAMPLES],
    input  cplx_weight_t w [NUM_CHANNELS],
    output cplx_sample_t expected [SAMPLES]
);
    longint  re_full;
    longint  im_full;
    sample_t acc_re;
    sample_t acc_im;
    for (int s = 0; s < SAMPLES; s++) begin
        acc_re = '0;
        acc_im = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            re_full = longint'(data[c][s].re) * longint'(w[c].re)
                    - longint'(data[c][s].im) * longint'(w[c].im);
            im_full = longint'(data[c][s].re) * longint'(w[c].im)
                    + longint'(data[c][s].im) * longint'(w[c].re);
            // shift, keep the low sample bits, and let the sum wrap
            acc_re = acc_re + sample_t'(re_full >>> WEIGHT_FRAC);
            acc_im = acc_im + sample_t'(im_full >>> WEIGHT_FRAC);
        end
        expected[s].re = acc_re;
        expected[s].im = acc_im;
    end
endfunction

task automatic compare_vector(
    input cplx_sample_t got [SAMPLES],
    input cplx_sample_t exp_vec [SAMPLES],
    inout int           errors
);
    for (int s = 0; s < SAMPLES; s++) begin
        if (got[s] !== exp_vec[s]) begin
            $display("FAILED at %0t: sample %0d got %h %h expected %h %h", $time, s,
                     got[s].re, got[s].im, exp_vec[s].re, exp_vec[s].im);
            errors++;
        end
    end
endtask

task automatic compare_last(input logic got, input logic exp_last, inout int errors);
    if (got !== exp_last) begin
        $display("FAILED at %0t: m_last got %b expected %b", $time, got, exp_last);
        errors++;
    end
endtask

`endif

//--- test/bf_tb.sv
/*
 * testbench for the four-channel complex beamformer
 * clock, reset, weight writes and beat stimulus on the falling edge
 * scoreboard queue filled at acceptance, compared at each output transfer
 * back-pressure, latency and timeout checks
 */
module bf_tb
    import bf_pkg::*;
();

    localparam int SAMPLES = 8;

    // reset, zero weights, one-hot weight, random streaming, back-pressure, last flags
    localparam int TOTAL_BEATS = 4 + 8 + 200 + 200 + 100;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 200;

    `include "bf_tb_model.svh"

    // one expected beat as recorded when the DUT took it
    typedef cplx_sample_t [SAMPLES-1:0] beat_vec_t;
    typedef struct packed {
        beat_vec_t data;
        logic      last;
        int        accept_cycle;
        logic      timed;
    } expect_t;

    logic          clock;
    logic          resetn;
    logic          s_valid;
    logic          s_ready;
    logic          s_last;
    cplx_sample_t  s_data [NUM_CHANNELS][SAMPLES];
    logic          m_ready;
    logic          m_valid;
    logic          m_last;
    cplx_sample_t  m_data [SAMPLES];
    logic          weight_we;
    weight_write_t weight_wr;

    // copy of the weights the DUT should hold
    cplx_weight_t  weights_model [NUM_CHANNELS];

    expect_t       exp_q [$];
    expect_t       new_entry;
    expect_t       head;
    cplx_sample_t  model_vec [SAMPLES];
    cplx_sample_t  exp_vec [SAMPLES];

    integer        seed = 32'h4a4b_5ac2;
    int            cycles = 0;
    int            value_errors = 0;
    int            protocol_errors = 0;
    logic          random_ready = 1'b0;

    beamformer_top #(
        .SAMPLES (SAMPLES)
    ) beamformer_top_i (
        .clock     (clock),
        .resetn    (resetn),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_last    (s_last),
        .s_data    (s_data),
        .m_ready   (m_ready),
        .m_valid   (m_valid),
        .m_last    (m_last),
        .m_data    (m_data),
        .weight_we (weight_we),
        .weight_wr (weight_wr)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // cycle counter for the run limit and the latency checks
    always @(posedge clock) begin
        cycles++;
    end

    // end the run if the stimulus or the DUT stops making progress
    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with %0d beats still expected",
                 cycles, exp_q.size());
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("sim failed");
        $finish;
    end

    // one falling edge, with a new random m_ready while back-pressure is on
    task automatic next_cycle();
        @(negedge clock);
        if (random_ready) begin
            m_ready = 1'($random(seed));
        end
    endtask

    // offer one random beat and hold it until the DUT takes it
    task automatic send_beat();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int s = 0; s < SAMPLES; s++) begin
                s_data[c][s].re = sample_t'($random(seed));
                s_data[c][s].im = sample_t'($random(seed));
            end
        end
        s_last = 1'($random(seed));
        s_valid = 1'b1;
        #2;
        while (!s_ready) begin
            next_cycle();
            #2;
        end
        next_cycle();
        s_valid = 1'b0;
    endtask

    // writes are only issued with the pipeline empty
    task automatic write_weight(input int channel, input weight_t re, input weight_t im);
        weight_we = 1'b1;
        weight_wr.channel = CHANNEL_INDEX_WIDTH'(channel);
        weight_wr.weight.re = re;
        weight_wr.weight.im = im;
        weights_model[channel].re = re;
        weights_model[channel].im = im;
        next_cycle();
        weight_we = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    // record the expected result of every accepted beat
    always @(negedge clock) begin
        #2;
        if (resetn && s_valid && s_ready) begin
            beam_model(s_data, weights_model, model_vec);
            for (int s = 0; s < SAMPLES; s++) begin
                new_entry.data[s] = model_vec[s];
            end
            new_entry.last = s_last;
            new_entry.accept_cycle = cycles;
            // latency is fixed only while m_ready stays high
            new_entry.timed = !random_ready;
            exp_q.push_back(new_entry);
        end
    end

    // compare every output transfer with the oldest expected beat
    always @(negedge clock) begin
        #2;
        if (!resetn) begin
            // the outputs are unknown until the first edge has applied reset
            if (cycles > 0 && (s_ready !== 1'b0 || m_valid !== 1'b0)) begin
                $display("s_ready or m_valid is not low while reset is asserted");
                protocol_errors++;
            end
        end else begin
            if (m_valid && !m_ready && s_ready) begin
                $display("s_ready is high while the output is stalled at time %0t", $time);
                protocol_errors++;
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at time %0t with no accepted input behind it", $time);
                    protocol_errors++;
                end else begin
                    head = exp_q.pop_front();
                    for (int s = 0; s < SAMPLES; s++) begin
                        exp_vec[s] = head.data[s];
                    end
                    compare_vector(m_data, exp_vec, value_errors);
                    compare_last(m_last, head.last, value_errors);
                    if (head.timed && (cycles - head.accept_cycle) != 3) begin
                        $display("FAILED at %0t: latency %0d cycles, expected 3", $time,
                                 cycles - head.accept_cycle);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        resetn = 1'b0;
        s_valid = 1'b0;
        s_last = 1'b0;
        m_ready = 1'b1;
        weight_we = 1'b0;
        weight_wr = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            weights_model[c] = '0;
            for (int s = 0; s < SAMPLES; s++) begin
                s_data[c][s] = '0;
            end
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;

        // weights are all zero after reset, so these beats come out as zeros
        repeat (4) send_beat();
        drain();

        // channel 0 at one half, the output is channel 0 shifted right by one
        write_weight(0, 8'sd64, 8'sd0);
        repeat (8) send_beat();
        drain();

        // random complex weights on every channel, streamed back to back
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            write_weight(c, weight_t'($random(seed)), weight_t'($random(seed)));
        end
        repeat (200) send_beat();
        drain();

        // random gaps on the input and random stalls on the output
        random_ready = 1'b1;
        repeat (200) begin
            while (($random(seed) & 1) != 0) begin
                next_cycle();
            end
            send_beat();
        end
        random_ready = 1'b0;
        m_ready = 1'b1;
        drain();

        // back to back beats with random last flags and fixed latency
        repeat (100) send_beat();
        drain();

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
logic/bf_pkg.sv
logic/weight_regs.sv
logic/channel_weighter.sv
logic/beam_combiner.sv
logic/beamformer_top.sv
test/bf_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the beamformer testbench with Verilator and runs it
# the exit status is nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module bf_tb -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build of bf_tb did not succeed"
    exit 1
fi

./obj_dir/Vbf_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    echo "testbench reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
    echo "testbench ended without a result line, see $LOG"
    exit 1
fi

exit 0
